//--- verilog.f
+incdir+.
bus_setup_pkg.sv
data_bank.sv
config_sequencer.sv
setup_fsm.sv
bus_setup_top.sv
bus_setup_chk.sv
tb_bus_setup.sv

//--- Bender.yml
package:
  name: bus_setup

sources:
  - include_dirs:
      - .
    files:
      - bus_setup_pkg.sv
      - data_bank.sv
      - config_sequencer.sv
      - setup_fsm.sv
      - bus_setup_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - bus_setup_chk.sv
      - tb_bus_setup.sv

//--- tb_bus_setup.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_setup_defs.svh"

module tb_bus_setup;

    import bus_setup_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int CFG_CYCLES   = `INT_MASTER_COUNT * `BANK_DEPTH * `SLOT_CYCLES;
    localparam int SETUP_CYCLES = 2 * 9 + 2 * 2 * `BANK_DEPTH;     // steps plus two full fills
    localparam int TEST_CYCLES  = 5 * (RESET_CYCLES + SETUP_CYCLES + 2 * CFG_CYCLES) + 100;

    logic                                clk;
    logic                                rstN;
    logic                                step;
    logic                                next_addr;
    sw_word_u                            sw;
    logic [`INT_MASTER_COUNT-1:0]        done_com;
    master_cmd_t [`INT_MASTER_COUNT-1:0] cmd;
    logic [3:0]                          status;

    int                     errors;
    integer                 seed;
    logic [`DATA_WIDTH-1:0] words [`INT_MASTER_COUNT][`BANK_DEPTH];  // words put into each bank
    int                     word_cnt [`INT_MASTER_COUNT];
    int                     first_exp [`INT_MASTER_COUNT];
    int                     last_exp [`INT_MASTER_COUNT];
    logic [1:0]             sid_exp [`INT_MASTER_COUNT];
    logic [`INT_MASTER_COUNT-1:0] ext_exp;

    bus_setup_top u_dut (
        .clk       (clk),
        .rstN      (rstN),
        .step      (step),
        .next_addr (next_addr),
        .sw        (sw),
        .done_com  (done_com),
        .cmd       (cmd),
        .status    (status)
    );

    bind bus_setup_top bus_setup_chk u_chk (
        .clk    (clk),
        .rstN   (rstN),
        .cmd    (cmd),
        .status (status)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s at %0t: expected %0h, actual %0h", name, $time, expected, actual);
        end
    endtask

    task automatic wait_status(input string name, input logic [3:0] lamps, input int limit);
        int n;
        n = 0;
        while (status !== lamps && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (status !== lamps) begin
            errors++;
            $display("%s: status lamps never showed %b within %0d cycles", name, lamps, limit);
        end
    endtask

    // last address of a burst, kept inside the slave
    function automatic int expected_last(input int first, input int len, input logic [1:0] sid);
        int depth;
        case (sid)
            2'd3:    depth = `SLAVE3_DEPTH;
            2'd2:    depth = `SLAVE2_DEPTH;
            default: depth = `SLAVE1_DEPTH;
        endcase
        return (first + len > depth - 1) ? depth - 1 : first + len;
    endfunction

    task automatic apply_reset();
        rstN      = 1'b0;
        step      = 1'b0;
        next_addr = 1'b0;
        sw        = '0;
        done_com  = '0;
        word_cnt  = '{default: 0};
        repeat (RESET_CYCLES) @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic press_step();
        @(negedge clk);
        step = 1'b1;
        @(negedge clk);
        step = 1'b0;
    endtask

    task automatic set_value(input logic [`DATA_WIDTH-1:0] v);
        sw            = '0;
        sw.value.word = v;
    endtask

    // slave ids, read/write and external-write choice, one step each
    task automatic select_fields(input logic [1:0] sid0, input logic [1:0] sid1,
                                 input logic [1:0] rw, input logic [1:0] ext);
        sw                  = '0;
        sw.pair.slave_id[0] = sid0;
        sw.pair.slave_id[1] = sid1;
        press_step();
        sw           = '0;
        sw.flag.bits = rw;
        press_step();
        sw           = '0;
        sw.flag.bits = ext;
        press_step();
        sid_exp[0] = sid0;
        sid_exp[1] = sid1;
        ext_exp    = ext;
    endtask

    task automatic fill_bank(input int m, input int n);
        for (int k = 0; k < n; k++) begin
            words[m][k] = $random(seed);
            set_value(words[m][k]);
            next_addr = 1'b1;
            @(negedge clk);
            next_addr = 1'b0;
            @(negedge clk);
        end
        word_cnt[m] = n;
    endtask

    task automatic enter_range(input logic [`ADDR_WIDTH-1:0] a0, input logic [`ADDR_WIDTH-1:0] l0,
                               input logic [`ADDR_WIDTH-1:0] a1, input logic [`ADDR_WIDTH-1:0] l1);
        set_value(a0);
        press_step();
        set_value(a1);
        press_step();
        set_value(l0);
        press_step();
        set_value(l1);
        press_step();   // now in configure
        first_exp[0] = a0;
        first_exp[1] = a1;
        last_exp[0]  = expected_last(a0, l0, sid_exp[0]);
        last_exp[1]  = expected_last(a1, l1, sid_exp[1]);
    endtask

    // slot stream of master 0 then master 1, one check per clock
    task automatic check_config(input string name);
        int nslots;
        int wi;
        for (int m = 0; m < `INT_MASTER_COUNT; m++) begin
            nslots = (ext_exp[m] && word_cnt[m] >= 2) ? word_cnt[m] : 2;
            for (int k = 0; k < nslots; k++) begin
                for (int c = 0; c < `SLOT_CYCLES; c++) begin
                    check_value({name, " status"}, 4'b0001, status);
                    check_value({name, " start"}, (c == 0) && (k == 0 || k == nslots - 1),
                                cmd[m].start);
                    check_value({name, " idle start"}, 0, cmd[1-m].start);
                    check_value({name, " address"}, (k == 0) ? first_exp[m] : last_exp[m],
                                cmd[m].address);
                    if (word_cnt[m] > 0) begin
                        wi = (k < word_cnt[m]) ? k : word_cnt[m] - 1;
                        check_value({name, " data"}, words[m][wi], cmd[m].data);
                    end
                    @(negedge clk);
                end
            end
        end
        wait_status(name, 4'b0010, CFG_CYCLES);
        check_value({name, " ready start"}, 0, {cmd[1].start, cmd[0].start});
        check_value({name, " ready address"}, 0, {cmd[1].address, cmd[0].address});
    endtask

    task automatic test_no_slave();
        apply_reset();
        check_value("reset status", 4'b0001, status);
        check_value("reset eoc", 2'b00, {cmd[1].eoc, cmd[0].eoc});
        press_step();
        check_value("no slave status", 4'b0100, status);
        check_value("no slave eoc", 2'b11, {cmd[1].eoc, cmd[0].eoc});
        @(negedge clk);
        check_value("no slave eoc end", 2'b00, {cmd[1].eoc, cmd[0].eoc});
    endtask

    task automatic test_field_capture();
        apply_reset();
        select_fields(2'd2, 2'd3, 2'b01, 2'b10);
        check_value("capture slave_id m1", 2'd2, cmd[0].slave_id);
        check_value("capture slave_id m2", 2'd3, cmd[1].slave_id);
        check_value("capture rd_wr", 2'b01, {cmd[1].rd_wr, cmd[0].rd_wr});
        check_value("capture in_ex", 2'b10, {cmd[1].in_ex, cmd[0].in_ex});
    endtask

    task automatic test_bank_config();
        apply_reset();
        select_fields(2'd1, 2'd2, 2'b00, 2'b01);
        fill_bank(0, 3);
        check_value("bank burst", 2'b01, {cmd[1].burst, cmd[0].burst});
        press_step();
        enter_range(12'd100, 12'd20, 12'd300, 12'd40);
        check_config("bank config");
    endtask

    // M2 bank filled here so its data stream is seen too
    task automatic test_clamp();
        apply_reset();
        select_fields(2'd3, 2'd1, 2'b10, 2'b10);
        fill_bank(1, 3);
        check_value("clamp burst", 2'b10, {cmd[1].burst, cmd[0].burst});
        press_step();
        enter_range(12'd2000, 12'd100, 12'd10, 12'd5);
        check_config("clamp");
    endtask

    // continues from the ready phase left by the clamp test
    task automatic test_launch_done();
        logic [`INT_MASTER_COUNT-1:0] launch;
        launch = '1;
        if (`COM_START_DELAY != 0) begin
            launch = 1 << `FIRST_START_MASTER;
        end
        press_step();
        check_value("launch start", launch, {cmd[1].start, cmd[0].start});
        check_value("launch status", 4'b1000, status);
        done_com = 2'b01;
        @(negedge clk);
        check_value("launch start end", 0, {cmd[1].start, cmd[0].start} & launch);
        check_value("one done status", 4'b1000, status);
        done_com = 2'b10;
        @(negedge clk);
        done_com = 2'b00;
        wait_status("both done", 4'b0100, 8);
        set_value(16'h0abc);
        @(negedge clk);
        check_value("done address m1", 12'habc, cmd[0].address);
        check_value("done address m2", 12'habc, cmd[1].address);
    endtask

    initial begin
        #(TEST_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the tests did not finish", TEST_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        clk    = 1'b0;
        errors = 0;
        seed   = 65007;
        test_no_slave();
        test_field_capture();
        test_bank_config();
        test_clamp();
        test_launch_done();
        $display("errors: %0d check, %0d assertion", errors, u_dut.u_chk.assert_fails);
        if (errors == 0 && u_dut.u_chk.assert_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bus_setup_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_setup_defs.svh"

module bus_setup_chk (
    input logic                                               clk,
    input logic                                               rstN,
    input bus_setup_pkg::master_cmd_t [`INT_MASTER_COUNT-1:0] cmd,
    input logic [3:0]                                         status
);

    int assert_fails = 0;

    status_one_hot: assert property (@(posedge clk) disable iff (!rstN) $onehot(status))
        else begin
            $error("status lamps not one-hot: %b", status);
            assert_fails++;
        end

    for (genvar m = 0; m < `INT_MASTER_COUNT; m++) begin : g_master
        // every start is a single-cycle pulse
        start_single: assert property (@(posedge clk) disable iff (!rstN)
            cmd[m].start |=> !cmd[m].start)
            else begin
                $error("start of master %0d high in two consecutive cycles", m);
                assert_fails++;
            end
        quiet_in_reset: assert property (@(posedge clk) !rstN |-> !cmd[m].start && !cmd[m].eoc)
            else begin
                $error("start or eoc of master %0d high during reset", m);
                assert_fails++;
            end
    end

endmodule

`default_nettype wire

//--- bus_setup_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_setup_defs.svh"

module bus_setup_top (
    input  logic                                               clk,
    input  logic                                               rstN,
    input  logic                                               step,
    input  logic                                               next_addr,
    input  bus_setup_pkg::sw_word_u                            sw,
    input  logic [`INT_MASTER_COUNT-1:0]                       done_com,
    output bus_setup_pkg::master_cmd_t [`INT_MASTER_COUNT-1:0] cmd,
    output logic [3:0]                                         status
);

    logic [`INT_MASTER_COUNT-1:0]                        bank_wr;
    logic                                                fill_clear;
    logic                                                cfg_go;
    logic                                                cfg_done;
    logic [`INT_MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]       first_addr;
    logic [`INT_MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]       last_addr;
    logic [`INT_MASTER_COUNT-1:0]                        in_ex;
    logic [`INT_MASTER_COUNT-1:0]                        burst;
    logic [`INT_MASTER_COUNT-1:0][$clog2(`BANK_DEPTH):0] wr_count;
    logic [$clog2(`INT_MASTER_COUNT)-1:0]                rd_master;
    logic [$clog2(`BANK_DEPTH)-1:0]                      rd_index;
    logic [`DATA_WIDTH-1:0]                              rd_word;
    logic [`INT_MASTER_COUNT-1:0]                        cfg_start;
    logic [`INT_MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]       cfg_address;
    logic [`INT_MASTER_COUNT-1:0][`DATA_WIDTH-1:0]       cfg_data;

    setup_fsm u_setup_fsm (
        .clk         (clk),
        .rstN        (rstN),
        .step        (step),
        .sw          (sw),
        .done_com    (done_com),
        .burst       (burst),
        .cfg_done    (cfg_done),
        .cfg_start   (cfg_start),
        .cfg_address (cfg_address),
        .cfg_data    (cfg_data),
        .bank_wr     (bank_wr),
        .fill_clear  (fill_clear),
        .cfg_go      (cfg_go),
        .first_addr  (first_addr),
        .last_addr   (last_addr),
        .in_ex       (in_ex),
        .cmd         (cmd),
        .status      (status)
    );

    data_bank u_data_bank (
        .clk        (clk),
        .rstN       (rstN),
        .bank_wr    (bank_wr),
        .fill_clear (fill_clear),
        .next_addr  (next_addr),
        .value      (sw.value.word),
        .rd_master  (rd_master),
        .rd_index   (rd_index),
        .rd_word    (rd_word),
        .wr_count   (wr_count),
        .burst      (burst)
    );

    config_sequencer u_config_sequencer (
        .clk         (clk),
        .rstN        (rstN),
        .go          (cfg_go),
        .first_addr  (first_addr),
        .last_addr   (last_addr),
        .in_ex       (in_ex),
        .wr_count    (wr_count),
        .rd_word     (rd_word),
        .rd_master   (rd_master),
        .rd_index    (rd_index),
        .cfg_start   (cfg_start),
        .cfg_address (cfg_address),
        .cfg_data    (cfg_data),
        .cfg_done    (cfg_done)
    );

endmodule

`default_nettype wire

//--- setup_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_setup_defs.svh"

module setup_fsm (
    input  logic                                          clk,
    input  logic                                          rstN,
    input  logic                                          step,
    input  bus_setup_pkg::sw_word_u                       sw,
    input  logic [`INT_MASTER_COUNT-1:0]                  done_com,
    input  logic [`INT_MASTER_COUNT-1:0]                  burst,
    input  logic                                          cfg_done,
    input  logic [`INT_MASTER_COUNT-1:0]                  cfg_start,
    input  logic [`INT_MASTER_COUNT-1:0][`ADDR_WIDTH-1:0] cfg_address,
    input  logic [`INT_MASTER_COUNT-1:0][`DATA_WIDTH-1:0] cfg_data,
    output logic [`INT_MASTER_COUNT-1:0]                  bank_wr,
    output logic                                          fill_clear,
    output logic                                          cfg_go,
    output logic [`INT_MASTER_COUNT-1:0][`ADDR_WIDTH-1:0] first_addr,
    output logic [`INT_MASTER_COUNT-1:0][`ADDR_WIDTH-1:0] last_addr,
    output logic [`INT_MASTER_COUNT-1:0]                  in_ex,
    output bus_setup_pkg::master_cmd_t [`INT_MASTER_COUNT-1:0] cmd,
    output logic [3:0]                                    status
);

    import bus_setup_pkg::*;

    localparam int DLY_W = ($clog2(`COM_START_DELAY + 1) > 0) ? $clog2(`COM_START_DELAY + 1) : 1;

    main_state_t                         state;
    main_state_t                         state_nx;
    logic [`INT_MASTER_COUNT-1:0][1:0]   slave_id;
    logic [`INT_MASTER_COUNT-1:0]        rd_wr;
    logic [`INT_MASTER_COUNT-1:0]        eoc;
    logic [`INT_MASTER_COUNT-1:0]        start_com;   // launch pulses
    logic [`INT_MASTER_COUNT-1:0]        seen_done;
    logic [`INT_MASTER_COUNT-1:0]        got_done;
    logic [`INT_MASTER_COUNT-1:0]        no_peer;     // master with no slave selected
    logic [DLY_W-1:0]                    dly_cnt;
    logic                                both_started;
    logic                                no_slave;
    logic [`ADDR_WIDTH-1:0]              sw_addr;

    // end of the burst, kept inside the selected slave
    function automatic logic [`ADDR_WIDTH-1:0] clamp_last(
        input logic [`ADDR_WIDTH-1:0] first,
        input logic [`ADDR_WIDTH-1:0] len,
        input logic [1:0]             sid
    );
        logic [`ADDR_WIDTH:0] sum;
        logic [`ADDR_WIDTH:0] depth;
        logic [`ADDR_WIDTH:0] lim;
        sum = first + len;
        case (sid)
            2'd2:    depth = (`ADDR_WIDTH+1)'(`SLAVE2_DEPTH);
            2'd3:    depth = (`ADDR_WIDTH+1)'(`SLAVE3_DEPTH);
            default: depth = (`ADDR_WIDTH+1)'(`SLAVE1_DEPTH);
        endcase
        lim = (sum >= depth) ? depth - 1'b1 : sum;
        return lim[`ADDR_WIDTH-1:0];
    endfunction

    assign sw_addr  = sw.value.word[`ADDR_WIDTH-1:0];
    assign no_slave = (sw.pair.slave_id == '0);
    assign got_done = seen_done | done_com;

    always_comb begin
        for (int m = 0; m < `INT_MASTER_COUNT; m++) begin
            no_peer[m] = (slave_id[m] == 2'd0);
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            slave_sel: if (step) state_nx = no_slave ? com_done : rw_sel;
            rw_sel:    if (step) state_nx = ext_sel;
            ext_sel: begin
                if (step) begin
                    case (sw.flag.bits)
                        2'b01:   state_nx = fill_m1;
                        2'b10:   state_nx = fill_m2;
                        2'b11:   state_nx = fill_m12;
                        default: state_nx = start_m1;   // no external writes
                    endcase
                end
            end
            fill_m12:         if (step) state_nx = fill_m2;
            fill_m1, fill_m2: if (step) state_nx = start_m1;
            start_m1:         if (step) state_nx = start_m2;
            start_m2:         if (step) state_nx = len_m1;
            len_m1:           if (step) state_nx = len_m2;
            len_m2:           if (step) state_nx = configure;
            configure:        if (cfg_done) state_nx = ready;
            ready:            if (step) state_nx = communicating;
            communicating:    if (&(got_done | no_peer)) state_nx = com_done;
            default: ;        // com_done holds until reset
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state        <= slave_sel;
            slave_id     <= '0;
            rd_wr        <= '0;
            in_ex        <= '0;
            first_addr   <= '0;
            last_addr    <= '0;
            eoc          <= '0;
            start_com    <= '0;
            seen_done    <= '0;
            dly_cnt      <= '0;
            both_started <= 1'b0;
        end else begin
            state     <= state_nx;
            eoc       <= {`INT_MASTER_COUNT{state == slave_sel && step && no_slave}};
            start_com <= '0;
            case (state)
                slave_sel: slave_id      <= sw.pair.slave_id;
                rw_sel:    rd_wr         <= sw.flag.bits;
                ext_sel:   in_ex         <= sw.flag.bits;
                start_m1:  first_addr[0] <= sw_addr;
                start_m2:  first_addr[1] <= sw_addr;
                len_m1:    last_addr[0]  <= clamp_last(first_addr[0], sw_addr, slave_id[0]);
                len_m2:    last_addr[1]  <= clamp_last(first_addr[1], sw_addr, slave_id[1]);
                ready: begin
                    if (step && `COM_START_DELAY == 0) begin
                        start_com    <= '1;
                        both_started <= 1'b1;
                    end else if (step) begin
                        start_com[`FIRST_START_MASTER] <= 1'b1;
                    end
                end
                communicating: begin
                    seen_done <= got_done;  // strobes are remembered
                    if (!both_started) begin
                        dly_cnt <= dly_cnt + 1'b1;
                        if (dly_cnt == DLY_W'(`COM_START_DELAY)) begin
                            start_com[1 - `FIRST_START_MASTER] <= 1'b1;
                            both_started <= 1'b1;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    assign bank_wr[0] = (state == fill_m1) || (state == fill_m12);
    assign bank_wr[1] = (state == fill_m2);
    assign fill_clear = step && (|bank_wr);
    assign cfg_go     = step && (state == len_m2);

    // sequencer owns start, address and data while configuring
    always_comb begin
        for (int m = 0; m < `INT_MASTER_COUNT; m++) begin
            cmd[m].burst    = burst[m];
            cmd[m].rd_wr    = rd_wr[m];
            cmd[m].in_ex    = in_ex[m];
            cmd[m].slave_id = slave_id[m];
            cmd[m].eoc      = eoc[m];
            cmd[m].start    = start_com[m];
            cmd[m].address  = (state == com_done) ? sw_addr : '0;   // read back after the run
            cmd[m].data     = '0;
            if (state == configure) begin
                cmd[m].start   = cfg_start[m];
                cmd[m].address = cfg_address[m];
                cmd[m].data    = cfg_data[m];
            end
        end
    end

    assign status[0] = !(state inside {ready, communicating, com_done});   // still in setup
    assign status[1] = (state == ready);
    assign status[2] = (state == com_done);
    assign status[3] = (state == communicating);

endmodule

`default_nettype wire

//--- config_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_setup_defs.svh"

module config_sequencer (
    input  logic                                                clk,
    input  logic                                                rstN,
    input  logic                                                go,
    input  logic [`INT_MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]       first_addr,
    input  logic [`INT_MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]       last_addr,
    input  logic [`INT_MASTER_COUNT-1:0]                        in_ex,
    input  logic [`INT_MASTER_COUNT-1:0][$clog2(`BANK_DEPTH):0] wr_count,
    input  logic [`DATA_WIDTH-1:0]                              rd_word,
    output logic [$clog2(`INT_MASTER_COUNT)-1:0]                rd_master,
    output logic [$clog2(`BANK_DEPTH)-1:0]                      rd_index,
    output logic [`INT_MASTER_COUNT-1:0]                        cfg_start,
    output logic [`INT_MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]       cfg_address,
    output logic [`INT_MASTER_COUNT-1:0][`DATA_WIDTH-1:0]       cfg_data,
    output logic                                                cfg_done
);

    import bus_setup_pkg::*;

    localparam int IDX_W = $clog2(`BANK_DEPTH);
    localparam int CNT_W = IDX_W + 1;
    localparam int CYC_W = ($clog2(`SLOT_CYCLES) > 0) ? $clog2(`SLOT_CYCLES) : 1;

    config_state_t                       state;
    logic [$clog2(`INT_MASTER_COUNT)-1:0] master;
    logic [CYC_W-1:0]                    cyc;         // cycle inside the slot
    logic [CNT_W-1:0]                    word;        // slot index of the current master
    logic [CNT_W-1:0]                    slots;
    logic [CNT_W-1:0]                    last_word;
    logic                                slot_end;

    // external writes play one slot per word, anything else gets first and last only
    always_comb begin
        slots = CNT_W'(2);
        if (in_ex[master] && wr_count[master] >= 2) begin
            slots = wr_count[master];
        end
        last_word = (wr_count[master] == '0) ? '0 : wr_count[master] - 1'b1;
    end

    assign slot_end = (cyc == CYC_W'(`SLOT_CYCLES - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state  <= conf_done;    // idle until the main FSM sends go
            master <= '0;
            cyc    <= '0;
            word   <= '0;
        end else if (go) begin
            state  <= conf_start;
            master <= '0;
            cyc    <= '0;
            word   <= '0;
        end else if (state != conf_done) begin
            cyc <= slot_end ? '0 : cyc + 1'b1;
            if (slot_end) begin
                word <= word + 1'b1;
                case (state)
                    conf_start: state <= (slots > 2) ? conf_middle : conf_last;
                    conf_middle: begin
                        if (word == slots - 2) begin
                            state <= conf_last;
                        end
                    end
                    conf_last: begin
                        word <= '0;
                        if (master == `INT_MASTER_COUNT - 1) begin
                            state <= conf_done;
                        end else begin
                            master <= master + 1'b1;
                            state  <= conf_start;
                        end
                    end
                    default: state <= conf_done;
                endcase
            end
        end
    end

    assign rd_master = master;
    assign rd_index  = (word > last_word) ? last_word[IDX_W-1:0] : word[IDX_W-1:0];
    assign cfg_done  = (state == conf_done);

    // only the master under configuration sees a slot stream
    always_comb begin
        cfg_start   = '0;
        cfg_address = '0;
        cfg_data    = '0;
        if (state != conf_done) begin
            cfg_start[master]   = (cyc == '0) && (state == conf_start || state == conf_last);
            cfg_address[master] = (state == conf_start) ? first_addr[master] : last_addr[master];
            cfg_data[master]    = rd_word;
        end
    end

endmodule

`default_nettype wire

//--- data_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_setup_defs.svh"

module data_bank (
    input  logic                                                clk,
    input  logic                                                rstN,
    input  logic [`INT_MASTER_COUNT-1:0]                        bank_wr,
    input  logic                                                fill_clear,
    input  logic                                                next_addr,
    input  logic [`DATA_WIDTH-1:0]                              value,
    input  logic [$clog2(`INT_MASTER_COUNT)-1:0]                rd_master,
    input  logic [$clog2(`BANK_DEPTH)-1:0]                      rd_index,
    output logic [`DATA_WIDTH-1:0]                              rd_word,
    output logic [`INT_MASTER_COUNT-1:0][$clog2(`BANK_DEPTH):0] wr_count,
    output logic [`INT_MASTER_COUNT-1:0]                        burst
);

    localparam int IDX_W = $clog2(`BANK_DEPTH);

    logic [`DATA_WIDTH-1:0] mem [`INT_MASTER_COUNT][`BANK_DEPTH];
    logic [IDX_W-1:0]       fill_ptr;   // shared, only one bank fills at a time

    // the current slot follows the switches until next_addr moves on
    always_ff @(posedge clk) begin
        for (int m = 0; m < `INT_MASTER_COUNT; m++) begin
            if (bank_wr[m]) begin
                mem[m][fill_ptr] <= value;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fill_ptr <= '0;
            wr_count <= '0;
            burst    <= '0;
        end else if (fill_clear) begin
            fill_ptr <= '0;                 // next bank starts at word 0
        end else if (next_addr && |bank_wr) begin
            fill_ptr <= fill_ptr + 1'b1;
            for (int m = 0; m < `INT_MASTER_COUNT; m++) begin
                if (bank_wr[m]) begin
                    burst[m] <= 1'b1;
                    if (wr_count[m] != `BANK_DEPTH) begin
                        wr_count[m] <= wr_count[m] + 1'b1;  // saturates at bank depth
                    end
                end
            end
        end
    end

    assign rd_word = mem[rd_master][rd_index];

endmodule

`default_nettype wire

//--- bus_setup_pkg.sv
`default_nettype none

`include "bus_setup_defs.svh"

package bus_setup_pkg;

    typedef enum logic [3:0] {
        slave_sel,
        rw_sel,
        ext_sel,
        fill_m1,
        fill_m2,
        fill_m12,       // M1 bank first, then M2
        start_m1,
        start_m2,
        len_m1,
        len_m2,
        configure,
        ready,
        communicating,
        com_done
    } main_state_t;

    typedef enum logic [1:0] {
        conf_start,
        conf_middle,
        conf_last,
        conf_done
    } config_state_t;

    // the switch bank means something different in each setup step
    typedef union packed {
        struct packed {
            logic [17-2*`INT_MASTER_COUNT:0]   pad;
            logic [`INT_MASTER_COUNT-1:0][1:0] slave_id;   // two bits per master
        } pair;
        struct packed {
            logic [17-`INT_MASTER_COUNT:0] pad;
            logic [`INT_MASTER_COUNT-1:0]  bits;    // one bit per master, or the bank code
        } flag;
        struct packed {
            logic [17-`DATA_WIDTH:0] pad;
            logic [`DATA_WIDTH-1:0]  word;    // data, address and length entry
        } value;
    } sw_word_u;

    typedef struct packed {
        logic                   burst;
        logic                   rd_wr;
        logic                   in_ex;
        logic [1:0]             slave_id;   // 0 means no slave
        logic [`ADDR_WIDTH-1:0] address;
        logic [`DATA_WIDTH-1:0] data;
        logic                   start;
        logic                   eoc;
    } master_cmd_t;

endpackage

`default_nettype wire

//--- bus_setup_defs.svh
`ifndef BUS_SETUP_DEFS_SVH
`define BUS_SETUP_DEFS_SVH

`define INT_MASTER_COUNT 2      // internal masters, sequencing is built for two
`define DATA_WIDTH 16
`define ADDR_WIDTH 12
`define BANK_DEPTH 16           // externally entered words per master

// configuration slot length in clock cycles
`define SLOT_CYCLES 2

`define SLAVE1_DEPTH 4096
`define SLAVE2_DEPTH 4096
`define SLAVE3_DEPTH 2048

// gap between the two communication starts, 0 starts both together
`define COM_START_DELAY 0
`define FIRST_START_MASTER 0

`endif
